// ==== compile.f ====
design/pe_pkg.sv
design/input_stage.sv
design/load_sequencer.sv
design/weight_bank.sv
design/activation_window.sv
design/product_array.sv
design/position_adder.sv
design/pe_top.sv
verification/pe_assert.sv
verification/pe_tb.sv

// ==== verification/pe_tb.sv ====
`timescale 1ns/1ps

module pe_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    // cycles with no beat after reset, outputs must stay at their reset values
    localparam int IDLE_CYCLES  = 5;
    // back-to-back beats, long enough to cross two frame boundaries
    localparam int RUN_BEATS    = 30;
    // cycles where in_valid is dropped at random
    localparam int STALL_CYCLES = 70;
    localparam int TAIL_CYCLES  = 3;
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RUN_BEATS +
                                  STALL_CYCLES + TAIL_CYCLES;
    localparam int TIMEOUT_NS   = TOTAL_CYCLES * CLK_PERIOD + 200;
    localparam int MAX_BEATS    = 128;
    localparam int PIXELS       = 12;
    localparam int unsigned SEED = 32'h768626a6;

    localparam int DW = pe_pkg::WORD_W * pe_pkg::WINDOW;
    localparam int CW = pe_pkg::COORD_W * pe_pkg::WINDOW;

    logic                                       clk = 1'b0;
    logic                                       irst_n;
    logic                                       in_valid;
    logic [pe_pkg::FRAME_W-1:0]                 pixels;
    logic [pe_pkg::CHANNEL_W-1:0]               in_channel;
    logic signed [pe_pkg::WORD_W-1:0]           weight;
    logic [pe_pkg::COORD_W-1:0]                 weight_cols;
    logic [pe_pkg::COORD_W-1:0]                 weight_rows;
    logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]    data_in;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]   data_in_cols;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]   data_in_rows;
    logic [pe_pkg::CHANNEL_W-1:0]               out_channel;
    logic [DW-1:0]                              data_out;
    logic [CW-1:0]                              data_out_cols;
    logic [CW-1:0]                              data_out_rows;
    logic                                       out_valid;

    // every presented beat is recorded here, indexed by beat number
    logic signed [pe_pkg::WORD_W-1:0]           hist_weight [MAX_BEATS];
    logic [pe_pkg::COORD_W-1:0]                 hist_wcol [MAX_BEATS];
    logic [pe_pkg::COORD_W-1:0]                 hist_wrow [MAX_BEATS];
    logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]    hist_data [MAX_BEATS];
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]   hist_dcol [MAX_BEATS];
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]   hist_drow [MAX_BEATS];
    logic [pe_pkg::CHANNEL_W-1:0]               hist_chan [MAX_BEATS];

    // number of beats the DUT has taken so far
    int          beats_done = 0;
    int          checks = 0;
    int          errors = 0;
    string       phase = "reset";
    int unsigned seed_state;

    logic                          exp_valid;
    logic [DW-1:0]                 exp_data;
    logic [CW-1:0]                 exp_cols;
    logic [CW-1:0]                 exp_rows;
    logic [pe_pkg::CHANNEL_W-1:0]  exp_chan;

    pe_top UUT (
        .clk           (clk),
        .irst_n        (irst_n),
        .in_valid      (in_valid),
        .pixels        (pixels),
        .in_channel    (in_channel),
        .weight        (weight),
        .weight_cols   (weight_cols),
        .weight_rows   (weight_rows),
        .data_in       (data_in),
        .data_in_cols  (data_in_cols),
        .data_in_rows  (data_in_rows),
        .out_channel   (out_channel),
        .data_out      (data_out),
        .data_out_cols (data_out_cols),
        .data_out_rows (data_out_rows),
        .out_valid     (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // weight slot written by beat n, or -1 when the beat writes none
    // beat 0 leaves idle, the first frame then counts beats 1 to PIXELS
    // and every later frame is PIXELS+1 beats long starting at counter 0
    function automatic int slot_of_beat(input int n);
        int c;
        if (n < 1) begin
            return -1;
        end
        if (n <= PIXELS) begin
            c = n;
        end else begin
            c = (n - PIXELS - 1) % (PIXELS + 1);
        end
        if (c >= 1 && c <= pe_pkg::LANES) begin
            return c - 1;
        end
        return -1;
    endfunction

    // expected outputs once n beats have been taken
    function automatic void predict(input int n, output logic valid,
                                    output logic [DW-1:0] words,
                                    output logic [CW-1:0] cols,
                                    output logic [CW-1:0] rows,
                                    output logic [pe_pkg::CHANNEL_W-1:0] chan);
        logic signed [pe_pkg::WORD_W-1:0] w [pe_pkg::LANES];
        logic [pe_pkg::COORD_W-1:0]       wc [pe_pkg::LANES];
        logic [pe_pkg::COORD_W-1:0]       wr [pe_pkg::LANES];
        logic signed [pe_pkg::WORD_W-1:0] act;
        logic signed [pe_pkg::PROD_W-1:0] prod;
        logic [pe_pkg::COORD_W-1:0]       acol;
        logic [pe_pkg::COORD_W-1:0]       arow;
        int s;
        int src;
        int p;
        int q;
        for (int i = 0; i < pe_pkg::LANES; i++) begin
            w[i]  = '0;
            wc[i] = '0;
            wr[i] = '0;
        end
        // a load beat stores the weight presented two beats before it
        for (int k = 0; k < n; k++) begin
            s = slot_of_beat(k);
            if (s >= 0) begin
                w[s]  = (k >= 2) ? hist_weight[k-2] : '0;
                wc[s] = (k >= 2) ? hist_wcol[k-2] : '0;
                wr[s] = (k >= 2) ? hist_wrow[k-2] : '0;
            end
        end
        valid = (n >= 2);
        chan  = (n >= 2) ? hist_chan[n-2] : '0;
        words = '0;
        cols  = '0;
        rows  = '0;
        for (int g = 0; g < pe_pkg::LANES; g++) begin
            // group g holds the activations of beat n-3-g
            src = n - 3 - g;
            for (int a = 0; a < pe_pkg::LANES; a++) begin
                p = g * pe_pkg::LANES + a;
                q = pe_pkg::WINDOW - 1 - p;
                act  = (src >= 0) ? hist_data[src][a*pe_pkg::WORD_W +: pe_pkg::WORD_W] : '0;
                acol = (src >= 0) ? hist_dcol[src][a*pe_pkg::COORD_W +: pe_pkg::COORD_W] : '0;
                arow = (src >= 0) ? hist_drow[src][a*pe_pkg::COORD_W +: pe_pkg::COORD_W] : '0;
                prod = w[g] * act;
                // bits 11 down to 4 of the signed product
                words[p*pe_pkg::WORD_W +: pe_pkg::WORD_W] = prod[11:4];
                if (valid) begin
                    cols[q*pe_pkg::COORD_W +: pe_pkg::COORD_W] = acol + wc[g];
                    rows[q*pe_pkg::COORD_W +: pe_pkg::COORD_W] = arow + wr[g];
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h at %0t ns", name, expected, actual,
                     $time);
        end
    endtask

    // one clock of stimulus, the next inputs go out just after the edge
    task automatic drive_cycle(input logic valid);
        @(posedge clk);
        if (in_valid) begin
            beats_done++;
        end
        #1;
        // inputs change even on idle cycles so a held value is really tested
        weight       = $urandom;
        weight_cols  = $urandom;
        weight_rows  = $urandom;
        data_in      = $urandom;
        data_in_cols = $urandom;
        data_in_rows = $urandom;
        in_channel   = $urandom;
        in_valid     = valid;
        if (valid && beats_done < MAX_BEATS) begin
            hist_weight[beats_done] = weight;
            hist_wcol[beats_done]   = weight_cols;
            hist_wrow[beats_done]   = weight_rows;
            hist_data[beats_done]   = data_in;
            hist_dcol[beats_done]   = data_in_cols;
            hist_drow[beats_done]   = data_in_rows;
            hist_chan[beats_done]   = in_channel;
        end
    endtask

    // outputs settle after the edge and the input update, so sample them mid-cycle
    always @(negedge clk) begin
        predict(beats_done, exp_valid, exp_data, exp_cols, exp_rows, exp_chan);
        check_value({phase, " out_valid"}, exp_valid, out_valid);
        check_value({phase, " data_out"}, exp_data, data_out);
        check_value({phase, " data_out_cols"}, exp_cols, data_out_cols);
        check_value({phase, " data_out_rows"}, exp_rows, data_out_rows);
        check_value({phase, " out_channel"}, exp_chan, out_channel);
    end

    initial begin
        seed_state   = $urandom(SEED);
        irst_n       = 1'b0;
        in_valid     = 1'b0;
        pixels       = PIXELS;
        in_channel   = '0;
        weight       = '0;
        weight_cols  = '0;
        weight_rows  = '0;
        data_in      = '0;
        data_in_cols = '0;
        data_in_rows = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        irst_n = 1'b1;
        phase = "idle";
        repeat (IDLE_CYCLES) drive_cycle(1'b0);
        // weight load, image beats and the wrap into the next frame
        phase = "frame";
        repeat (RUN_BEATS) drive_cycle(1'b1);
        // roughly one cycle in four carries no beat
        phase = "stall";
        repeat (STALL_CYCLES) drive_cycle(($urandom % 4) != 0);
        phase = "tail";
        repeat (TAIL_CYCLES) drive_cycle(1'b0);
        @(negedge clk);
        #1;
        $display("beats %0d, checks %0d, errors %0d", beats_done, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // the run is bounded by the scheduled cycles plus some slack
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the stimulus finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/pe_assert.sv ====
`timescale 1ns/1ps

module pe_assert (
    input logic                                       clk,
    input logic                                       irst_n,
    input logic [1:0]                                 state,
    input logic                                       out_valid,
    input logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]  data_out_cols
);

    // valid is sticky until the next reset
    assert property (@(posedge clk) disable iff (!irst_n) out_valid |=> out_valid)
        else $error("out_valid fell after it had been set");

    // code 3 has no meaning in the sequencer
    assert property (@(posedge clk) disable iff (!irst_n) state != 2'd3)
        else $error("load sequencer entered the unused state code");

    // position sums are gated until the first weight beat
    assert property (@(posedge clk) disable iff (!irst_n) !out_valid |-> data_out_cols == '0)
        else $error("data_out_cols is nonzero while out_valid is low");

endmodule

// the sequencer state is picked up from inside the top level
bind pe_top pe_assert u_pe_assert (
    .clk           (clk),
    .irst_n        (irst_n),
    .state         (u_load_sequencer.state),
    .out_valid     (out_valid),
    .data_out_cols (data_out_cols)
);

// ==== design/pe_top.sv ====
`timescale 1ns/1ps

module pe_top (
    input  logic                                        clk,
    input  logic                                        irst_n,
    input  logic                                        in_valid,
    input  logic [pe_pkg::FRAME_W-1:0]                  pixels,
    input  logic [pe_pkg::CHANNEL_W-1:0]                in_channel,
    input  logic signed [pe_pkg::WORD_W-1:0]            weight,
    input  logic [pe_pkg::COORD_W-1:0]                  weight_cols,
    input  logic [pe_pkg::COORD_W-1:0]                  weight_rows,
    input  logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]     data_in,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]    data_in_cols,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]    data_in_rows,
    output logic [pe_pkg::CHANNEL_W-1:0]                out_channel,
    output logic [pe_pkg::WORD_W*pe_pkg::WINDOW-1:0]    data_out,
    output logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   data_out_cols,
    output logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   data_out_rows,
    output logic                                        out_valid
);

    // delayed input fields
    logic signed [pe_pkg::WORD_W-1:0]          d_weight;
    logic [pe_pkg::COORD_W-1:0]                d_weight_col;
    logic [pe_pkg::COORD_W-1:0]                d_weight_row;
    logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]   d_data;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]  d_data_cols;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]  d_data_rows;

    logic [pe_pkg::LANES-1:0]                  weight_we;

    // stored weights and the live window
    logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]   weights;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]  weight_cols_q;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]  weight_rows_q;
    logic [pe_pkg::WORD_W*pe_pkg::WINDOW-1:0]  window;
    logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0] window_cols;
    logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0] window_rows;

    // the delayed channel tag goes straight out
    input_stage u_input_stage (
        .clk          (clk),
        .irst_n       (irst_n),
        .in_valid     (in_valid),
        .weight       (weight),
        .weight_cols  (weight_cols),
        .weight_rows  (weight_rows),
        .data_in      (data_in),
        .data_in_cols (data_in_cols),
        .data_in_rows (data_in_rows),
        .in_channel   (in_channel),
        .d_weight     (d_weight),
        .d_weight_col (d_weight_col),
        .d_weight_row (d_weight_row),
        .d_data       (d_data),
        .d_data_cols  (d_data_cols),
        .d_data_rows  (d_data_rows),
        .d_channel    (out_channel)
    );

    load_sequencer u_load_sequencer (
        .clk       (clk),
        .irst_n    (irst_n),
        .in_valid  (in_valid),
        .pixels    (pixels),
        .weight_we (weight_we),
        .out_valid (out_valid)
    );

    weight_bank u_weight_bank (
        .clk           (clk),
        .irst_n        (irst_n),
        .weight_we     (weight_we),
        .d_weight      (d_weight),
        .d_weight_col  (d_weight_col),
        .d_weight_row  (d_weight_row),
        .weights       (weights),
        .weight_cols_q (weight_cols_q),
        .weight_rows_q (weight_rows_q)
    );

    activation_window u_activation_window (
        .clk         (clk),
        .irst_n      (irst_n),
        .in_valid    (in_valid),
        .d_data      (d_data),
        .d_data_cols (d_data_cols),
        .d_data_rows (d_data_rows),
        .window      (window),
        .window_cols (window_cols),
        .window_rows (window_rows)
    );

    // both arithmetic blocks are combinational, outputs follow the beat edge directly
    product_array u_product_array (
        .weights  (weights),
        .window   (window),
        .data_out (data_out)
    );

    position_adder u_position_adder (
        .out_valid     (out_valid),
        .weight_cols_q (weight_cols_q),
        .weight_rows_q (weight_rows_q),
        .window_cols   (window_cols),
        .window_rows   (window_rows),
        .data_out_cols (data_out_cols),
        .data_out_rows (data_out_rows)
    );

endmodule

// ==== design/position_adder.sv ====
`timescale 1ns/1ps

module position_adder (
    input  logic                                        out_valid,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]    weight_cols_q,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]    weight_rows_q,
    input  logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   window_cols,
    input  logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   window_rows,
    output logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   data_out_cols,
    output logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   data_out_rows
);

    // pairing is the same as in the product array
    for (genvar g = 0; g < pe_pkg::LANES; g++) begin : g_group
        for (genvar a = 0; a < pe_pkg::LANES; a++) begin : g_lane
            localparam int P = g * pe_pkg::LANES + a;
            // packing is reversed here, pair 0 sits at the top of the vector
            localparam int Q = pe_pkg::WINDOW - 1 - P;

            logic [pe_pkg::COORD_W-1:0] col_sum;
            logic [pe_pkg::COORD_W-1:0] row_sum;

            // five-bit result, so the sums wrap modulo 32
            assign col_sum = window_cols[P*pe_pkg::COORD_W +: pe_pkg::COORD_W] +
                             weight_cols_q[g*pe_pkg::COORD_W +: pe_pkg::COORD_W];
            assign row_sum = window_rows[P*pe_pkg::COORD_W +: pe_pkg::COORD_W] +
                             weight_rows_q[g*pe_pkg::COORD_W +: pe_pkg::COORD_W];

            // positions mean nothing before the first weight beat
            assign data_out_cols[Q*pe_pkg::COORD_W +: pe_pkg::COORD_W] =
                out_valid ? col_sum : '0;
            assign data_out_rows[Q*pe_pkg::COORD_W +: pe_pkg::COORD_W] =
                out_valid ? row_sum : '0;
        end
    end

endmodule

// ==== design/product_array.sv ====
`timescale 1ns/1ps

module product_array (
    input  logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]   weights,
    input  logic [pe_pkg::WORD_W*pe_pkg::WINDOW-1:0]  window,
    output logic [pe_pkg::WORD_W*pe_pkg::WINDOW-1:0]  data_out
);

    // group g of the window is multiplied by weight slot g
    // activation a of that group becomes output word g*4+a
    for (genvar g = 0; g < pe_pkg::LANES; g++) begin : g_group
        for (genvar a = 0; a < pe_pkg::LANES; a++) begin : g_lane
            localparam int P = g * pe_pkg::LANES + a;

            logic signed [pe_pkg::PROD_W-1:0] prod;

            // both operands are two's complement
            assign prod = $signed(weights[g*pe_pkg::WORD_W +: pe_pkg::WORD_W]) *
                          $signed(window[P*pe_pkg::WORD_W +: pe_pkg::WORD_W]);

            // middle slice of the product, upper bits are dropped without saturation
            assign data_out[P*pe_pkg::WORD_W +: pe_pkg::WORD_W] =
                prod[pe_pkg::SLICE_LSB +: pe_pkg::WORD_W];
        end
    end

endmodule

// ==== design/activation_window.sv ====
`timescale 1ns/1ps

module activation_window (
    input  logic                                        clk,
    input  logic                                        irst_n,
    input  logic                                        in_valid,
    input  logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]     d_data,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]    d_data_cols,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]    d_data_rows,
    output logic [pe_pkg::WORD_W*pe_pkg::WINDOW-1:0]    window,
    output logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   window_cols,
    output logic [pe_pkg::COORD_W*pe_pkg::WINDOW-1:0]   window_rows
);

    // bits kept from the older groups when a new group enters
    localparam int KEEP_D = pe_pkg::WORD_W * (pe_pkg::WINDOW - pe_pkg::LANES);
    localparam int KEEP_C = pe_pkg::COORD_W * (pe_pkg::WINDOW - pe_pkg::LANES);

    // group 0 is the least significant group and always holds the newest
    // activations, group 3 drops off the top on every beat
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            window      <= '0;
            window_cols <= '0;
            window_rows <= '0;
        end else if (in_valid) begin
            window      <= {window[KEEP_D-1:0], d_data};
            window_cols <= {window_cols[KEEP_C-1:0], d_data_cols};
            window_rows <= {window_rows[KEEP_C-1:0], d_data_rows};
        end
    end

endmodule

// ==== design/weight_bank.sv ====
`timescale 1ns/1ps

module weight_bank (
    input  logic                                      clk,
    input  logic                                      irst_n,
    input  logic [pe_pkg::LANES-1:0]                  weight_we,
    input  logic signed [pe_pkg::WORD_W-1:0]          d_weight,
    input  logic [pe_pkg::COORD_W-1:0]                d_weight_col,
    input  logic [pe_pkg::COORD_W-1:0]                d_weight_row,
    output logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]   weights,
    output logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]  weight_cols_q,
    output logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]  weight_rows_q
);

    // slot i sits at bits i*width upward in each packed vector
    // a weight and its two offsets always land in the same slot
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            // all slots are zero until the first frame loads them
            weights       <= '0;
            weight_cols_q <= '0;
            weight_rows_q <= '0;
        end else begin
            for (int i = 0; i < pe_pkg::LANES; i++) begin
                // each enable is independent
                // the sequencer never raises more than one at a time
                if (weight_we[i]) begin
                    weights[i*pe_pkg::WORD_W +: pe_pkg::WORD_W]         <= d_weight;
                    weight_cols_q[i*pe_pkg::COORD_W +: pe_pkg::COORD_W] <= d_weight_col;
                    weight_rows_q[i*pe_pkg::COORD_W +: pe_pkg::COORD_W] <= d_weight_row;
                end
            end
        end
    end

endmodule

// ==== design/load_sequencer.sv ====
`timescale 1ns/1ps

module load_sequencer (
    input  logic                         clk,
    input  logic                         irst_n,
    input  logic                         in_valid,
    input  logic [pe_pkg::FRAME_W-1:0]   pixels,
    output logic [pe_pkg::LANES-1:0]     weight_we,
    output logic                         out_valid
);

    logic [1:0]                 state;
    logic [pe_pkg::FRAME_W-1:0] count;
    // weight slot addressed by the current load beat
    logic [1:0]                 slot_sel;
    logic                       load_beat;

    // counter values 1 to 4 map onto slots 0 to 3
    assign slot_sel = count[1:0] - 2'd1;

    // a load beat at counter 0 only happens right after a frame wrap
    // and must not touch any slot
    assign load_beat = in_valid && (state == pe_pkg::ST_LOAD_WEIGHT) &&
                       (count >= 1) && (count <= pe_pkg::WEIGHT_BEATS);

    always_comb begin
        weight_we = '0;
        if (load_beat) begin
            weight_we[slot_sel] = 1'b1;
        end
    end

    // state and beat counter only move on presented beats
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            state <= pe_pkg::ST_IDLE;
            count <= '0;
        end else if (in_valid) begin
            case (state)
                pe_pkg::ST_IDLE: begin
                    state <= pe_pkg::ST_LOAD_WEIGHT;
                    count <= count + 1'b1;
                end
                pe_pkg::ST_LOAD_WEIGHT: begin
                    // the last weight beat hands over to the image phase
                    if (count == pe_pkg::WEIGHT_BEATS) begin
                        state <= pe_pkg::ST_LOAD_IMAGE;
                    end
                    count <= count + 1'b1;
                end
                pe_pkg::ST_LOAD_IMAGE: begin
                    // frame end, restart weight loading from counter 0
                    if (count == pixels) begin
                        state <= pe_pkg::ST_LOAD_WEIGHT;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= pe_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // valid goes high on the first weight beat and stays up until reset
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            out_valid <= 1'b0;
        end else if (in_valid && state == pe_pkg::ST_LOAD_WEIGHT) begin
            out_valid <= 1'b1;
        end
    end

endmodule

// ==== design/input_stage.sv ====
`timescale 1ns/1ps

module input_stage (
    input  logic                                          clk,
    input  logic                                          irst_n,
    input  logic                                          in_valid,
    input  logic signed [pe_pkg::WORD_W-1:0]              weight,
    input  logic [pe_pkg::COORD_W-1:0]                    weight_cols,
    input  logic [pe_pkg::COORD_W-1:0]                    weight_rows,
    input  logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]       data_in,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]      data_in_cols,
    input  logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]      data_in_rows,
    input  logic [pe_pkg::CHANNEL_W-1:0]                  in_channel,
    output logic signed [pe_pkg::WORD_W-1:0]              d_weight,
    output logic [pe_pkg::COORD_W-1:0]                    d_weight_col,
    output logic [pe_pkg::COORD_W-1:0]                    d_weight_row,
    output logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]       d_data,
    output logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]      d_data_cols,
    output logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0]      d_data_rows,
    output logic [pe_pkg::CHANNEL_W-1:0]                  d_channel
);

    // the first register of each field feeds the output register
    logic signed [pe_pkg::WORD_W-1:0]         s1_weight;
    logic [pe_pkg::COORD_W-1:0]               s1_weight_col;
    logic [pe_pkg::COORD_W-1:0]               s1_weight_row;
    logic [pe_pkg::WORD_W*pe_pkg::LANES-1:0]  s1_data;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0] s1_data_cols;
    logic [pe_pkg::COORD_W*pe_pkg::LANES-1:0] s1_data_rows;
    logic [pe_pkg::CHANNEL_W-1:0]             s1_channel;

    // all fields move together so weights, activations and the sequencer stay aligned
    // the stage holds when no beat is presented
    // both registers read zero until two beats have passed
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            s1_weight     <= '0;
            s1_weight_col <= '0;
            s1_weight_row <= '0;
            s1_data       <= '0;
            s1_data_cols  <= '0;
            s1_data_rows  <= '0;
            s1_channel    <= '0;
            d_weight      <= '0;
            d_weight_col  <= '0;
            d_weight_row  <= '0;
            d_data        <= '0;
            d_data_cols   <= '0;
            d_data_rows   <= '0;
            d_channel     <= '0;
        end else if (in_valid) begin
            s1_weight     <= weight;
            s1_weight_col <= weight_cols;
            s1_weight_row <= weight_rows;
            s1_data       <= data_in;
            s1_data_cols  <= data_in_cols;
            s1_data_rows  <= data_in_rows;
            s1_channel    <= in_channel;
            d_weight      <= s1_weight;
            d_weight_col  <= s1_weight_col;
            d_weight_row  <= s1_weight_row;
            d_data        <= s1_data;
            d_data_cols   <= s1_data_cols;
            d_data_rows   <= s1_data_rows;
            d_channel     <= s1_channel;
        end
    end

endmodule

// ==== design/pe_pkg.sv ====
package pe_pkg;

    // width of one weight and of one activation
    localparam int WORD_W = 8;

    // width of a column or row position, sums wrap at this width
    localparam int COORD_W = 5;

    // one weight per group, and four activations share each weight
    localparam int LANES = 4;

    // the full window is a square of lanes
    localparam int WINDOW = LANES * LANES;

    // a signed 8 by 8 product needs sixteen bits
    localparam int PROD_W = 2 * WORD_W;

    // the output keeps bits 11 down to 4 of each product
    localparam int SLICE_LSB = 4;

    // frame length input and beat counter share this width
    localparam int FRAME_W = 16;

    // channel tag carried alongside the data
    localparam int CHANNEL_W = 6;

    // number of weight beats at the start of every frame
    localparam int WEIGHT_BEATS = 4;

    // load sequencer state codes
    // code 2'b11 is never entered and falls back to idle
    localparam logic [1:0] ST_IDLE        = 2'd0;
    localparam logic [1:0] ST_LOAD_WEIGHT = 2'd1;
    localparam logic [1:0] ST_LOAD_IMAGE  = 2'd2;

endpackage
